/* generals.f */
+incdir+common
common/generals_pkg.sv
game/board_store.sv
game/game_control.sv
display/pixel_locator.sv
display/tile_painter.sv
logic/generals_top.sv
verif/generals_properties.sv
verif/generals_tb.sv

/* verif/generals_tb.sv */
`default_nettype none
`include "generals_defs.svh"

module generals_tb import generals_pkg::*; ();

    // upper bound on keys sent in the whole run
    localparam int MAX_OPS = 400;
    localparam int LIMIT = 2000 + 20 * MAX_OPS;

    logic              clock;
    logic              rst_n;
    logic              keyboard_ready;
    logic [2:0]        keyboard_data;
    logic [`PIX_W-1:0] hdata;
    logic [`PIX_W-1:0] vdata;
    wire               keyboard_read_fin;
    wire  [7:0]        gen_red;
    wire  [7:0]        gen_green;
    wire  [7:0]        gen_blue;
    wire               use_gen;
    player_e           turn;
    player_e           winner;

    int checks;
    int errors;
    int ops;

    // reference board and game state indexed [h][v]
    player_e      b_owner [`BOARD_WIDTH][`BOARD_WIDTH];
    piece_e       b_piece [`BOARD_WIDTH][`BOARD_WIDTH];
    int           b_troop [`BOARD_WIDTH][`BOARD_WIDTH];
    int           cur_h;
    int           cur_v;
    cursor_mode_e m_mode;
    player_e      m_turn;
    player_e      m_winner;

    // each word is one move with nibbles h, v, key code and half flag
    logic [15:0] red_script [13] = '{16'h3320, 16'h3420, 16'h3520, 16'h3620, 16'h3730,
        16'h4701, 16'h4700, 16'h4620, 16'h4720, 16'h4830, 16'h5830, 16'h6830, 16'h7830};
    // blue army circles next to the mountain while its crown keeps one troop
    logic [15:0] blue_script [13] = '{16'h8710, 16'h7700, 16'h7600, 16'h7510, 16'h6520,
        16'h6630, 16'h7600, 16'h7510, 16'h6520, 16'h6630, 16'h7600, 16'h7510, 16'h6520};

    generals_top generals_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        repeat (LIMIT) @(posedge clock);
        $display("timeout: run still busy after %0d cycles, %0d keys sent", LIMIT, ops);
        $display("Checks failed");
        $finish;
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("Error at time %0t: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic model_reset();
        for (int h = 0; h < `BOARD_WIDTH; h++) begin
            for (int v = 0; v < `BOARD_WIDTH; v++) begin
                b_owner[h][v] = NPC;
                b_piece[h][v] = TERRITORY;
                b_troop[h][v] = 0;
            end
        end
        b_owner[`RED_CROWN_H][`RED_CROWN_V] = RED;
        b_piece[`RED_CROWN_H][`RED_CROWN_V] = CROWN;
        b_troop[`RED_CROWN_H][`RED_CROWN_V] = `RED_TROOPS;
        b_owner[`BLUE_CROWN_H][`BLUE_CROWN_V] = BLUE;
        b_piece[`BLUE_CROWN_H][`BLUE_CROWN_V] = CROWN;
        b_troop[`BLUE_CROWN_H][`BLUE_CROWN_V] = `BLUE_TROOPS;
        b_piece[`MOUNTAIN_H][`MOUNTAIN_V] = MOUNTAIN;
        b_piece[`CITY_H][`CITY_V] = CITY;
        b_troop[`CITY_H][`CITY_V] = `CITY_TROOPS;
        cur_h = `RED_CROWN_H;
        cur_v = `RED_CROWN_V;
        m_mode = CHOOSE;
        m_turn = RED;
        m_winner = NPC;
    endtask

    // game rules applied to one resolved key
    task automatic model_key(input logic [2:0] code);
        int nh;
        int nv;
        int amount;
        logic on_board;
        if (code > 3'd5 || m_winner != NPC) return;
        nh = cur_h;
        nv = cur_v;
        case (code)
            W: nv = cur_v - 1;
            A: nh = cur_h - 1;
            S: nv = cur_v + 1;
            D: nh = cur_h + 1;
            default: nh = -1;
        endcase
        on_board = nh >= 0 && nh < `BOARD_WIDTH && nv >= 0 && nv < `BOARD_WIDTH;
        if (m_mode == CHOOSE) begin
            if (code == SPACE) begin
                if (b_owner[cur_h][cur_v] == m_turn) m_mode = MOVE_TOTAL;
            end else if (on_board) begin
                cur_h = nh;
                cur_v = nv;
            end
        end else if (code == SPACE) begin
            m_mode = CHOOSE;
        end else if (code == Z) begin
            m_mode = (m_mode == MOVE_TOTAL) ? MOVE_HALF : MOVE_TOTAL;
        end else if (on_board && b_piece[nh][nv] != MOUNTAIN && b_troop[cur_h][cur_v] >= 2) begin
            amount = (m_mode == MOVE_HALF) ? b_troop[cur_h][cur_v] / 2 : b_troop[cur_h][cur_v] - 1;
            b_troop[cur_h][cur_v] -= amount;
            if (b_owner[nh][nv] == m_turn) begin
                b_troop[nh][nv] = (b_troop[nh][nv] + amount > 511) ? 511 : b_troop[nh][nv] + amount;
            end else if (amount > b_troop[nh][nv]) begin
                b_owner[nh][nv] = m_turn;
                b_troop[nh][nv] = amount - b_troop[nh][nv];
                if (b_piece[nh][nv] == CROWN) begin
                    b_piece[nh][nv] = CITY;
                    m_winner = m_turn;
                end
            end else begin
                b_troop[nh][nv] -= amount;
            end
            if (m_winner == NPC) begin
                m_turn = (m_turn == RED) ? BLUE : RED;
                cur_h = (m_turn == RED) ? `RED_CROWN_H : `BLUE_CROWN_H;
                cur_v = (m_turn == RED) ? `RED_CROWN_V : `BLUE_CROWN_V;
                m_mode = CHOOSE;
            end
        end
    endtask

    // {use_gen, rgb} expected for a pixel inside a tile
    function automatic logic [24:0] pixel_expect(input int h, input int v,
                                                 input int oh, input int ov);
        logic [24:0] res;
        res = '0;
        if (h == cur_h && v == cur_v && (oh == 1 || oh == 49 || ov == 1 || ov == 49)) begin
            res = {1'b1, `PAL_CURSOR};
        end else if (b_owner[h][v] == RED) begin
            res = {1'b1, (b_piece[h][v] == CROWN) ? `PAL_RED_CROWN : `PAL_RED_LAND};
        end else if (b_owner[h][v] == BLUE) begin
            res = {1'b1, (b_piece[h][v] == CROWN) ? `PAL_BLUE_CROWN : `PAL_BLUE_LAND};
        end else if (b_piece[h][v] == MOUNTAIN) begin
            res = {1'b1, `PAL_MOUNTAIN};
        end else if (b_piece[h][v] == CITY) begin
            res = {1'b1, `PAL_NPC_CITY};
        end
        return res;
    endfunction

    // present a pixel and check the registered colour
    task automatic probe(input int px, input int py, input logic [24:0] expected,
                         input string what);
        hdata = `PIX_W'(px);
        vdata = `PIX_W'(py);
        @(posedge clock);
        @(posedge clock);
        #1;
        check_eq({7'b0, use_gen, gen_red, gen_green, gen_blue}, {7'b0, expected}, what);
    endtask

    task automatic check_tile(input int h, input int v, input int oh, input int ov);
        probe(`BOARD_ORG + h * `TILE_PIX + oh, `BOARD_ORG + v * `TILE_PIX + ov,
              pixel_expect(h, v, oh, ov), $sformatf("pixel of tile (%0d,%0d)", h, v));
    endtask

    // one key and then state and outline against the model
    task automatic press(input logic [2:0] code);
        keyboard_data = code;
        keyboard_ready = 1'b1;
        do begin
            @(posedge clock);
            #1;
        end while (!keyboard_read_fin);
        keyboard_ready = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        ops++;
        model_key(code);
        check_eq(32'(turn), 32'(m_turn), "turn");
        check_eq(32'(winner), 32'(m_winner), "winner");
        check_tile(cur_h, cur_v, 1, 25);
    endtask

    // unknown code arrives while the valid key is still pending
    task automatic press_then_invalid(input logic [2:0] code, input logic [2:0] junk);
        keyboard_data = code;
        keyboard_ready = 1'b1;
        do begin
            @(posedge clock);
            #1;
        end while (!keyboard_read_fin);
        keyboard_data = junk;
        @(posedge clock);
        #1;
        keyboard_ready = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        ops += 2;
        model_key(code);
        check_eq(32'(turn), 32'(m_turn), "turn");
        check_eq(32'(winner), 32'(m_winner), "winner");
        check_tile(cur_h, cur_v, 1, 25);
    endtask

    // cursor walk in choose mode
    task automatic goto(input int h, input int v);
        while (cur_h != h || cur_v != v) begin
            if (cur_h < h) press(D);
            else if (cur_h > h) press(A);
            else if (cur_v < v) press(S);
            else press(W);
        end
    endtask

    task automatic play(input logic [15:0] mv);
        int h;
        int v;
        int nh;
        int nv;
        h = mv[15:12];
        v = mv[11:8];
        nh = h;
        nv = v;
        case (mv[6:4])
            W: nv = v - 1;
            A: nh = h - 1;
            S: nv = v + 1;
            default: nh = h + 1;
        endcase
        goto(h, v);
        press(SPACE);
        if (mv[0]) press(Z);
        press(mv[6:4]);
        check_tile(h, v, 25, 25);
        check_tile(nh, nv, 25, 25);
    endtask

    initial begin
        void'($urandom(63));
        rst_n = 1'b0;
        keyboard_ready = 1'b0;
        keyboard_data = '0;
        hdata = '0;
        vdata = '0;
        checks = 0;
        errors = 0;
        ops = 0;
        model_reset();
        repeat (5) @(posedge clock);
        #1;
        rst_n = 1'b1;
        // reset picture with the outline on the red crown
        check_eq(32'(turn), 32'(RED), "turn after reset");
        check_eq(32'(winner), 32'(NPC), "winner after reset");
        check_tile(2, 3, 1, 25);
        check_tile(8, 7, 25, 25);
        check_tile(0, 0, 25, 25);
        check_tile(5, 5, 25, 25);
        probe(100, 300, '0, "grid pixel");
        probe(20, 600, '0, "pixel outside the board");
        // cursor clamps at the left and top edges
        repeat (3) press(A);
        repeat (4) press(W);
        for (int i = 0; i < 30; i++) begin
            press(3'($urandom % 4));
        end
        // neutral cell, Z and unknown codes leave choose mode as is
        goto(0, 0);
        press(SPACE);
        press(Z);
        press_then_invalid(D, 3'd7);
        press_then_invalid(S, 3'd6);
        press(D);
        // first red move in total mode
        play(16'h2330);
        // blue half move off its crown
        play(16'h8711);
        // red crown is down to one troop
        press(SPACE);
        press(D);
        press(SPACE);
        for (int i = 0; i < 13; i++) begin
            play(red_script[i]);
            if (i == 4) begin
                // blue tries the mountain first
                goto(6, 5);
                press(SPACE);
                press(A);
                press(SPACE);
            end
            play(blue_script[i]);
        end
        // red takes the blue crown
        play(16'h8800);
        check_eq(32'(winner), 32'(RED), "winner after crown capture");
        press(D);
        press(SPACE);
        press(S);
        press(Z);
        check_tile(8, 7, 25, 25);
        check_tile(4, 6, 25, 25);
        check_tile(8, 8, 25, 25);
        $display("%0d checks, %0d errors, %0d assertion failures, %0d keys",
                 checks, errors, generals_top_i.props_i.fail_count, ops);
        if (errors == 0 && generals_top_i.props_i.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/generals_properties.sv */
`default_nettype none
`include "generals_defs.svh"

module generals_properties import generals_pkg::*; (
    input  wire                   clock,
    input  wire                   rst_n,
    input  wire                   keyboard_ready,
    input  wire                   keyboard_read_fin,
    input  wire  [`PIX_W-1:0]     hdata,
    input  wire  [`PIX_W-1:0]     vdata,
    input  wire                   use_gen,
    input  player_e               winner
);

    // read by the testbench summary
    int unsigned fail_count = 0;
    logic        off_board;
    logic        grid_pix;

    assign off_board = (hdata < `BOARD_ORG) || (hdata > `BOARD_END) ||
                       (vdata < `BOARD_ORG) || (vdata > `BOARD_END);
    // only meaningful inside the board square
    assign grid_pix = (hdata % `TILE_PIX == 0) || (vdata % `TILE_PIX == 0);

    // read strobe cleared by reset
    fin_reset: assert property (@(posedge clock) !rst_n |=> !keyboard_read_fin)
        else begin
            fail_count++;
            $error("keyboard_read_fin high in the cycle after reset");
        end

    // strobe is ready delayed by one cycle
    fin_follows: assert property (@(posedge clock)
        rst_n |=> keyboard_read_fin == $past(keyboard_ready))
        else begin
            fail_count++;
            $error("keyboard_read_fin does not follow keyboard_ready");
        end

    // grid lines and border left to the background
    blank: assert property (@(posedge clock) rst_n && (off_board || grid_pix) |=> !use_gen)
        else begin
            fail_count++;
            $error("use_gen high for a grid or off-board pixel");
        end

    winner_held: assert property (@(posedge clock) rst_n && winner != NPC |=> $stable(winner))
        else begin
            fail_count++;
            $error("winner changed after the game ended");
        end

endmodule

bind generals_top generals_properties props_i (.*);

`default_nettype wire

/* logic/generals_top.sv */
`default_nettype none
`include "generals_defs.svh"

module generals_top import generals_pkg::*; (
    input  wire                   clock,
    input  wire                   rst_n,
    input  wire                   keyboard_ready,
    input  wire  [2:0]            keyboard_data,
    input  wire  [`PIX_W-1:0]     hdata,
    input  wire  [`PIX_W-1:0]     vdata,
    output wire                   keyboard_read_fin,
    output wire  [7:0]            gen_red,
    output wire  [7:0]            gen_green,
    output wire  [7:0]            gen_blue,
    output wire                   use_gen,
    output player_e               turn,
    output player_e               winner
);

    // game side
    wire [`COORD_W-1:0] cursor_h;
    wire [`COORD_W-1:0] cursor_v;
    wire [`COORD_W-1:0] dst_h;
    wire [`COORD_W-1:0] dst_v;
    player_e            src_owner;
    piece_e             src_piece;
    wire [`TROOP_W-1:0] src_troop;
    player_e            dst_owner;
    piece_e             dst_piece;
    wire [`TROOP_W-1:0] dst_troop;
    wire                src_we;
    wire [`TROOP_W-1:0] src_wtroop;
    wire                dst_we;
    player_e            dst_wowner;
    piece_e             dst_wpiece;
    wire [`TROOP_W-1:0] dst_wtroop;
    // display side
    wire [`COORD_W-1:0] tile_h;
    wire [`COORD_W-1:0] tile_v;
    wire [`OFF_W-1:0]   off_h;
    wire [`OFF_W-1:0]   off_v;
    wire                in_board;
    wire                on_grid;
    player_e            pix_owner;
    piece_e             pix_piece;

    game_control game_control_i (
        .clock(clock), .rst_n(rst_n),
        .keyboard_ready(keyboard_ready), .keyboard_data(keyboard_data),
        .src_owner(src_owner), .src_piece(src_piece), .src_troop(src_troop),
        .dst_owner(dst_owner), .dst_piece(dst_piece), .dst_troop(dst_troop),
        .keyboard_read_fin(keyboard_read_fin),
        .cursor_h(cursor_h), .cursor_v(cursor_v), .dst_h(dst_h), .dst_v(dst_v),
        .src_we(src_we), .src_wtroop(src_wtroop),
        .dst_we(dst_we), .dst_wowner(dst_wowner), .dst_wpiece(dst_wpiece),
        .dst_wtroop(dst_wtroop), .turn(turn), .winner(winner)
    );

    // source read port follows the cursor
    board_store board_store_i (
        .clock(clock), .rst_n(rst_n),
        .src_h(cursor_h), .src_v(cursor_v), .dst_h(dst_h), .dst_v(dst_v),
        .pix_h(tile_h), .pix_v(tile_v),
        .src_we(src_we), .src_wtroop(src_wtroop),
        .dst_we(dst_we), .dst_wowner(dst_wowner), .dst_wpiece(dst_wpiece),
        .dst_wtroop(dst_wtroop),
        .src_owner(src_owner), .src_piece(src_piece), .src_troop(src_troop),
        .dst_owner(dst_owner), .dst_piece(dst_piece), .dst_troop(dst_troop),
        .pix_owner(pix_owner), .pix_piece(pix_piece)
    );

    pixel_locator pixel_locator_i (
        .hdata(hdata), .vdata(vdata),
        .tile_h(tile_h), .tile_v(tile_v), .off_h(off_h), .off_v(off_v),
        .in_board(in_board), .on_grid(on_grid)
    );

    tile_painter tile_painter_i (
        .clock(clock), .rst_n(rst_n),
        .tile_h(tile_h), .tile_v(tile_v), .off_h(off_h), .off_v(off_v),
        .in_board(in_board), .on_grid(on_grid),
        .cursor_h(cursor_h), .cursor_v(cursor_v),
        .pix_owner(pix_owner), .pix_piece(pix_piece),
        .gen_red(gen_red), .gen_green(gen_green), .gen_blue(gen_blue),
        .use_gen(use_gen)
    );

endmodule

`default_nettype wire

/* display/tile_painter.sv */
`default_nettype none
`include "generals_defs.svh"

module tile_painter import generals_pkg::*; (
    input  wire                   clock,
    input  wire                   rst_n,
    input  wire  [`COORD_W-1:0]   tile_h,
    input  wire  [`COORD_W-1:0]   tile_v,
    input  wire  [`OFF_W-1:0]     off_h,
    input  wire  [`OFF_W-1:0]     off_v,
    input  wire                   in_board,
    input  wire                   on_grid,
    input  wire  [`COORD_W-1:0]   cursor_h,
    input  wire  [`COORD_W-1:0]   cursor_v,
    input  player_e               pix_owner,
    input  piece_e                pix_piece,
    output logic [7:0]            gen_red,
    output logic [7:0]            gen_green,
    output logic [7:0]            gen_blue,
    output logic                  use_gen
);

    logic [23:0] color;
    logic        show;
    logic        outline;

    // one-pixel ring just inside the grid lines
    assign outline = (tile_h == cursor_h) && (tile_v == cursor_v) &&
                     (off_h == `OFF_W'(1) || off_h == `OFF_W'(`TILE_PIX - 1) ||
                      off_v == `OFF_W'(1) || off_v == `OFF_W'(`TILE_PIX - 1));

    always_comb begin
        color = '0;
        show = 1'b0;
        if (on_grid || !in_board) begin
            // grid and border come from the background
            show = 1'b0;
        end else if (outline) begin
            color = `PAL_CURSOR;
            show = 1'b1;
        end else begin
            show = 1'b1;
            case (pix_owner)
                RED:  color = (pix_piece == CROWN) ? `PAL_RED_CROWN : `PAL_RED_LAND;
                BLUE: color = (pix_piece == CROWN) ? `PAL_BLUE_CROWN : `PAL_BLUE_LAND;
                default: begin
                    // neutral: mountain, city, or empty ground
                    if (pix_piece == MOUNTAIN) color = `PAL_MOUNTAIN;
                    else if (pix_piece == TERRITORY) show = 1'b0;
                    else color = `PAL_NPC_CITY;
                end
            endcase
        end
    end

    // one register stage from pixel to colour
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            gen_red <= '0;
            gen_green <= '0;
            gen_blue <= '0;
            use_gen <= 1'b0;
        end else begin
            gen_red <= color[23:16];
            gen_green <= color[15:8];
            gen_blue <= color[7:0];
            use_gen <= show;
        end
    end

endmodule

`default_nettype wire

/* display/pixel_locator.sv */
`default_nettype none
`include "generals_defs.svh"

module pixel_locator (
    input  wire  [`PIX_W-1:0]     hdata,
    input  wire  [`PIX_W-1:0]     vdata,
    output logic [`COORD_W-1:0]   tile_h,
    output logic [`COORD_W-1:0]   tile_v,
    output logic [`OFF_W-1:0]     off_h,
    output logic [`OFF_W-1:0]     off_v,
    output logic                  in_board,
    output logic                  on_grid
);

    logic grid_h;
    logic grid_v;

    // compare table per axis, no divider
    function automatic void locate(
        input  logic [`PIX_W-1:0]   pix,
        output logic [`COORD_W-1:0] tile,
        output logic [`OFF_W-1:0]   off,
        output logic                grid
    );
        logic [`PIX_W-1:0] base;
        tile = '0;
        off = '0;
        grid = 1'b0;
        for (int i = 0; i <= `BOARD_WIDTH; i++) begin
            base = `PIX_W'(`BOARD_ORG + i * `TILE_PIX);
            // tile i spans base up to base + 49
            if (i < `BOARD_WIDTH && pix >= base && pix < base + `TILE_PIX) begin
                tile = `COORD_W'(i);
                off = `OFF_W'(pix - base);
            end
            // 11 grid lines from 50 through 550
            if (pix == base) begin
                grid = 1'b1;
            end
        end
    endfunction

    always_comb begin
        locate(hdata, tile_h, off_h, grid_h);
        locate(vdata, tile_v, off_v, grid_v);
    end

    assign in_board = (hdata >= `BOARD_ORG) && (hdata <= `BOARD_END) &&
                      (vdata >= `BOARD_ORG) && (vdata <= `BOARD_END);
    // a grid pixel only counts inside the board square
    assign on_grid = in_board && (grid_h || grid_v);

endmodule

`default_nettype wire

/* game/game_control.sv */
`default_nettype none
`include "generals_defs.svh"

module game_control import generals_pkg::*; (
    input  wire                   clock,
    input  wire                   rst_n,
    input  wire                   keyboard_ready,
    input  wire  [2:0]            keyboard_data,
    input  player_e               src_owner,
    input  piece_e                src_piece,
    input  wire  [`TROOP_W-1:0]   src_troop,
    input  player_e               dst_owner,
    input  piece_e                dst_piece,
    input  wire  [`TROOP_W-1:0]   dst_troop,
    output logic                  keyboard_read_fin,
    output logic [`COORD_W-1:0]   cursor_h,
    output logic [`COORD_W-1:0]   cursor_v,
    output logic [`COORD_W-1:0]   dst_h,
    output logic [`COORD_W-1:0]   dst_v,
    output logic                  src_we,
    output logic [`TROOP_W-1:0]   src_wtroop,
    output logic                  dst_we,
    output player_e               dst_wowner,
    output piece_e                dst_wpiece,
    output logic [`TROOP_W-1:0]   dst_wtroop,
    output player_e               turn,
    output player_e               winner
);

    operation_e        op;
    cursor_mode_e      mode;
    player_e           next_player;
    logic              dst_on_board;
    logic              resolve;
    logic              move_ok;
    logic              crown_taken;
    logic [`TROOP_W-1:0] amount;
    logic [`TROOP_W:0]   sum;

    // an operation settles on the first edge with ready low
    assign resolve = !keyboard_ready && (op != NONE) && (winner == NPC);
    assign next_player = (turn == RED) ? BLUE : RED;

    // neighbour cell in the direction of the pending key
    always_comb begin
        dst_h = cursor_h;
        dst_v = cursor_v;
        dst_on_board = 1'b1;
        case (op)
            W: if (cursor_v == '0) dst_on_board = 1'b0; else dst_v = cursor_v - 1'b1;
            S: if (cursor_v == `COORD_W'(`BOARD_WIDTH - 1)) dst_on_board = 1'b0;
               else dst_v = cursor_v + 1'b1;
            A: if (cursor_h == '0) dst_on_board = 1'b0; else dst_h = cursor_h - 1'b1;
            D: if (cursor_h == `COORD_W'(`BOARD_WIDTH - 1)) dst_on_board = 1'b0;
               else dst_h = cursor_h + 1'b1;
            default: dst_on_board = 1'b0;
        endcase
    end

    // troops leaving the source, source always keeps at least one
    assign amount = (mode == MOVE_HALF) ? (src_troop >> 1) : (src_troop - 1'b1);
    assign sum = {1'b0, dst_troop} + {1'b0, amount};

    // source must be own land with something to spare
    assign move_ok = resolve && mode[1] && dst_on_board && (dst_piece != MOUNTAIN) &&
                     (src_owner == turn) && (src_piece != MOUNTAIN) && (src_troop >= 2);

    always_comb begin
        src_we = move_ok;
        dst_we = move_ok;
        src_wtroop = src_troop - amount;
        dst_wowner = dst_owner;
        dst_wpiece = dst_piece;
        crown_taken = 1'b0;
        if (dst_owner == turn) begin
            // reinforce, saturating
            dst_wtroop = sum[`TROOP_W] ? '1 : sum[`TROOP_W-1:0];
        end else if (amount > dst_troop) begin
            // capture, a taken crown becomes a city
            dst_wowner = turn;
            dst_wtroop = amount - dst_troop;
            if (dst_piece == CROWN) begin
                dst_wpiece = CITY;
                crown_taken = 1'b1;
            end
        end else begin
            dst_wtroop = dst_troop - amount;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            op <= NONE;
            keyboard_read_fin <= 1'b0;
            cursor_h <= `RED_CROWN_H;
            cursor_v <= `RED_CROWN_V;
            mode <= CHOOSE;
            turn <= RED;
            winner <= NPC;
        end else if (keyboard_ready) begin
            keyboard_read_fin <= 1'b1;
            // newer code replaces an unresolved one
            if (keyboard_data <= 3'd5) begin
                op <= operation_e'(keyboard_data);
            end
        end else begin
            keyboard_read_fin <= 1'b0;
            // after a win the slot just drains
            if (op != NONE) begin
                op <= NONE;
            end
            if (resolve && !mode[1]) begin
                case (op)
                    SPACE: if (src_owner == turn) mode <= MOVE_TOTAL;
                    Z: mode <= CHOOSE;
                    // edge clamp comes from the neighbour check
                    default: if (dst_on_board) begin
                        cursor_h <= dst_h;
                        cursor_v <= dst_v;
                    end
                endcase
            end else if (resolve) begin
                case (op)
                    SPACE: mode <= CHOOSE;
                    Z: mode <= (mode == MOVE_TOTAL) ? MOVE_HALF : MOVE_TOTAL;
                    default: if (move_ok) begin
                        if (crown_taken) begin
                            winner <= turn;
                        end else begin
                            // hand over to the other player at their crown
                            turn <= next_player;
                            cursor_h <= (next_player == RED) ? `RED_CROWN_H : `BLUE_CROWN_H;
                            cursor_v <= (next_player == RED) ? `RED_CROWN_V : `BLUE_CROWN_V;
                            mode <= CHOOSE;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* game/board_store.sv */
`default_nettype none
`include "generals_defs.svh"

module board_store import generals_pkg::*; (
    input  wire                   clock,
    input  wire                   rst_n,
    input  wire  [`COORD_W-1:0]   src_h,
    input  wire  [`COORD_W-1:0]   src_v,
    input  wire  [`COORD_W-1:0]   dst_h,
    input  wire  [`COORD_W-1:0]   dst_v,
    input  wire  [`COORD_W-1:0]   pix_h,
    input  wire  [`COORD_W-1:0]   pix_v,
    input  wire                   src_we,
    input  wire  [`TROOP_W-1:0]   src_wtroop,
    input  wire                   dst_we,
    input  player_e               dst_wowner,
    input  piece_e                dst_wpiece,
    input  wire  [`TROOP_W-1:0]   dst_wtroop,
    output player_e               src_owner,
    output piece_e                src_piece,
    output logic [`TROOP_W-1:0]   src_troop,
    output player_e               dst_owner,
    output piece_e                dst_piece,
    output logic [`TROOP_W-1:0]   dst_troop,
    output player_e               pix_owner,
    output piece_e                pix_piece
);

    // indexed [h][v]
    player_e           owner_q [`BOARD_WIDTH][`BOARD_WIDTH];
    piece_e            piece_q [`BOARD_WIDTH][`BOARD_WIDTH];
    logic [`TROOP_W-1:0] troop_q [`BOARD_WIDTH][`BOARD_WIDTH];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            // empty neutral ground everywhere
            for (int h = 0; h < `BOARD_WIDTH; h++) begin
                for (int v = 0; v < `BOARD_WIDTH; v++) begin
                    owner_q[h][v] <= NPC;
                    piece_q[h][v] <= TERRITORY;
                    troop_q[h][v] <= '0;
                end
            end
            // then the fixed pieces on top
            owner_q[`RED_CROWN_H][`RED_CROWN_V] <= RED;
            piece_q[`RED_CROWN_H][`RED_CROWN_V] <= CROWN;
            troop_q[`RED_CROWN_H][`RED_CROWN_V] <= `RED_TROOPS;
            owner_q[`BLUE_CROWN_H][`BLUE_CROWN_V] <= BLUE;
            piece_q[`BLUE_CROWN_H][`BLUE_CROWN_V] <= CROWN;
            troop_q[`BLUE_CROWN_H][`BLUE_CROWN_V] <= `BLUE_TROOPS;
            piece_q[`MOUNTAIN_H][`MOUNTAIN_V] <= MOUNTAIN;
            piece_q[`CITY_H][`CITY_V] <= CITY;
            troop_q[`CITY_H][`CITY_V] <= `CITY_TROOPS;
        end else begin
            // source keeps owner and piece, only troops change
            if (src_we) begin
                troop_q[src_h][src_v] <= src_wtroop;
            end
            if (dst_we) begin
                owner_q[dst_h][dst_v] <= dst_wowner;
                piece_q[dst_h][dst_v] <= dst_wpiece;
                troop_q[dst_h][dst_v] <= dst_wtroop;
            end
        end
    end

    // combinational read ports
    assign src_owner = owner_q[src_h][src_v];
    assign src_piece = piece_q[src_h][src_v];
    assign src_troop = troop_q[src_h][src_v];
    assign dst_owner = owner_q[dst_h][dst_v];
    assign dst_piece = piece_q[dst_h][dst_v];
    assign dst_troop = troop_q[dst_h][dst_v];
    // display port needs no troops
    assign pix_owner = owner_q[pix_h][pix_v];
    assign pix_piece = piece_q[pix_h][pix_v];

endmodule

`default_nettype wire

/* common/generals_pkg.sv */
`default_nettype none

package generals_pkg;

    // owner of a cell, NPC for neutral ground
    typedef enum logic [1:0] {
        NPC,
        RED,
        BLUE
    } player_e;

    typedef enum logic [1:0] {
        TERRITORY,
        MOUNTAIN,
        CROWN,
        CITY
    } piece_e;

    // upper bit set means a move mode
    typedef enum logic [1:0] {
        CHOOSE     = 2'b00,
        MOVE_TOTAL = 2'b10,
        MOVE_HALF  = 2'b11
    } cursor_mode_e;

    // keyboard decoder codes, NONE marks an empty slot
    typedef enum logic [2:0] {
        W     = 3'd0,
        A     = 3'd1,
        S     = 3'd2,
        D     = 3'd3,
        SPACE = 3'd4,
        Z     = 3'd5,
        NONE  = 3'd6
    } operation_e;

endpackage

`default_nettype wire

/* common/generals_defs.svh */
`ifndef GENERALS_DEFS_SVH
`define GENERALS_DEFS_SVH

// board geometry
`define BOARD_WIDTH     10
`define COORD_W         4
// troop counts saturate at 511
`define TROOP_W         9

// vga pixel geometry, tiles are 50 pixels wide
`define PIX_W           10
`define OFF_W           6
`define TILE_PIX        50
`define BOARD_ORG       50
`define BOARD_END       550

// start layout
`define RED_CROWN_H     4'd2
`define RED_CROWN_V     4'd3
`define BLUE_CROWN_H    4'd8
`define BLUE_CROWN_V    4'd7
`define MOUNTAIN_H      4'd5
`define MOUNTAIN_V      4'd5
`define CITY_H          4'd4
`define CITY_V          4'd6
`define RED_TROOPS      9'd87
`define BLUE_TROOPS     9'd89
`define CITY_TROOPS     9'd40

// palette as 24-bit rgb, red in the top byte
`define PAL_RED_CROWN   24'hc80000
`define PAL_RED_LAND    24'hff6060
`define PAL_BLUE_CROWN  24'h0000c8
`define PAL_BLUE_LAND   24'h6060ff
`define PAL_MOUNTAIN    24'h808080
`define PAL_NPC_CITY    24'ha0a0a0
`define PAL_CURSOR      24'hffffff

`endif
